/* all.f */
lcd_pkg.sv
lcd_wr_if.sv
lcd_cmd_sequencer.sv
lcd_bus_driver.sv
lcd_ctrl_top.sv
tb_lcd_ctrl.sv

/* Bender.yml */
package:
  name: lcd_ctrl

sources:
  - lcd_pkg.sv
  - lcd_wr_if.sv
  - lcd_cmd_sequencer.sv
  - lcd_bus_driver.sv
  - lcd_ctrl_top.sv
  - target: test
    files:
      - tb_lcd_ctrl.sv

/* tb_lcd_ctrl.sv */
// testbench module with stimulus table, lcd bus monitor, window checks and cycle timeout
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_ctrl;

    import lcd_pkg::*;

    localparam int CLK_FREQ = 200_000;
    // init is about 3700 cycles and every other entry under 330 so 20000 leaves wide margin
    localparam int TIMEOUT_CYCLES = 20_000;

    // one host request and the windows it should produce
    typedef struct {
        logic [2:0] func;
        logic [7:0] data;
        int         n_win;
        logic       rs;
        logic [7:0] bval;
        lcd_wait_t  wsel;
    } stim_t;

    // one expected E-high window
    typedef struct {
        logic       rs;
        logic [7:0] bval;
        int         width;
    } win_t;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_req;
    lcd_func_t             i_func;
    logic [LCD_DATA_W-1:0] i_data;
    logic                  o_ack;
    logic                  o_lcd_e;
    logic                  o_lcd_rs;
    logic [LCD_DATA_W-1:0] o_lcd_data;

    stim_t      tbl[$];
    win_t       exp_q[$];
    int         err_count = 0;
    int         win_count = 0;
    int         cyc = 0;
    int         hi_cnt = 0;
    logic       prev_e = 1'b0;
    logic       cur_rs;
    logic [7:0] cur_data;
    logic       gap_check = 1'b0;
    int         gap_start = 0;

    lcd_ctrl_top #(
        .CLK_FREQ (CLK_FREQ)
    ) lcd_ctrl_top_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_func     (i_func),
        .i_data     (i_data),
        .o_ack      (o_ack),
        .o_lcd_e    (o_lcd_e),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_data (o_lcd_data)
    );

    always #50 i_clk = ~i_clk;

    // run length guard
    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles, a handshake never completed", cyc);
            $display("windows checked: %0d, errors: %0d", win_count, err_count);
            $display("Test failed");
            $finish;
        end
    end

    // hold time is frequency times duration truncated to whole cycles
    function automatic int width_for(input lcd_wait_t w);
        longint unsigned dur_ns;
        case (w)
            WAIT_100US:  dur_ns = 100_000;
            WAIT_1_52MS: dur_ns = 1_520_000;
            WAIT_4_1MS:  dur_ns = 4_100_000;
            WAIT_10MS:   dur_ns = 10_000_000;
            default:     dur_ns = 37_000;
        endcase
        return int'((longint'(CLK_FREQ) * dur_ns) / 64'd1_000_000_000);
    endfunction

    task automatic add_stim(input logic [2:0] func, input logic [7:0] data, input int n_win,
                            input logic rs, input logic [7:0] bval, input lcd_wait_t wsel);
        tbl.push_back('{func, data, n_win, rs, bval, wsel});
    endtask

    // nine power-up commands after the 10 ms settle
    task automatic expect_init();
        logic [7:0] bytes [9] = '{8'h38, 8'h38, 8'h38, 8'h38, 8'h08, 8'h01, 8'h02, 8'h06, 8'h0C};
        lcd_wait_t  waits [9] = '{WAIT_4_1MS, WAIT_100US, WAIT_100US, WAIT_100US, WAIT_37US,
                                  WAIT_1_52MS, WAIT_1_52MS, WAIT_37US, WAIT_37US};
        for (int k = 0; k < 9; k++) begin
            exp_q.push_back('{1'b0, bytes[k], width_for(waits[k])});
        end
    endtask

    // all lcd outputs and ack quiet
    task automatic check_idle(input string when_s);
        if ({o_ack, o_lcd_e, o_lcd_rs, o_lcd_data} !== 11'h000) begin
            err_count++;
            $display("mismatch at %0t: {o_ack,o_lcd_e,o_lcd_rs,o_lcd_data} expected 000 got %h (%s)",
                     $time, {o_ack, o_lcd_e, o_lcd_rs, o_lcd_data}, when_s);
        end
    endtask

    // full four-phase request with windows matched by the monitor
    task automatic run_entry(input stim_t s);
        int seen;
        seen = win_count;
        if (s.func == FUNC_INIT) begin
            expect_init();
        end else if (s.n_win == 1) begin
            exp_q.push_back('{s.rs, s.bval, width_for(s.wsel)});
        end
        @(posedge i_clk);
        i_req  <= 1'b1;
        i_func <= lcd_func_t'(s.func);
        i_data <= s.data;
        if (s.func == FUNC_INIT) begin
            gap_check = 1'b1;
            gap_start = cyc;
        end
        do @(negedge i_clk); while (!o_ack);
        if (exp_q.size() != 0) begin
            err_count++;
            $display("error at %0t: o_ack rose with %0d E windows still missing", $time, exp_q.size());
        end
        if (win_count - seen != s.n_win) begin
            err_count++;
            $display("error at %0t: func %0d gave %0d E windows instead of %0d",
                     $time, s.func, win_count - seen, s.n_win);
        end
        @(posedge i_clk);
        i_req <= 1'b0;
        @(negedge i_clk);
        if (!o_ack) begin
            err_count++;
            $display("error at %0t: o_ack dropped while i_req was still high", $time);
        end
        do @(negedge i_clk); while (o_ack);
    endtask

    // E window recorder sampled mid-cycle
    always @(negedge i_clk) begin : bus_monitor
        win_t exp_w;
        if (i_rst_n) begin
            if (o_ack && o_lcd_e) begin
                err_count++;
                $display("error at %0t: o_ack high while E still high", $time);
            end
            if (o_lcd_e && !prev_e) begin
                hi_cnt   = 1;
                cur_rs   = o_lcd_rs;
                cur_data = o_lcd_data;
                // power-up wait ahead of the first init strobe
                if (gap_check) begin
                    gap_check = 1'b0;
                    if (cyc - gap_start < width_for(WAIT_10MS)) begin
                        err_count++;
                        $display("error at %0t: first init strobe only %0d cycles after request",
                                 $time, cyc - gap_start);
                    end
                end
            end else if (o_lcd_e) begin
                hi_cnt++;
                if (o_lcd_rs !== cur_rs || o_lcd_data !== cur_data) begin
                    err_count++;
                    $display("error at %0t: rs or data moved while E high", $time);
                end
            end else if (prev_e) begin
                win_count++;
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("error at %0t: E window with no request expecting one", $time);
                end else begin
                    exp_w = exp_q.pop_front();
                    if (cur_rs !== exp_w.rs) begin
                        err_count++;
                        $display("mismatch at %0t: o_lcd_rs expected %b got %b",
                                 $time, exp_w.rs, cur_rs);
                    end
                    if (cur_data !== exp_w.bval) begin
                        err_count++;
                        $display("mismatch at %0t: o_lcd_data expected %h got %h",
                                 $time, exp_w.bval, cur_data);
                    end
                    if (hi_cnt != exp_w.width) begin
                        err_count++;
                        $display("mismatch at %0t: o_lcd_e width expected %0d got %0d",
                                 $time, exp_w.width, hi_cnt);
                    end
                end
            end
        end
        prev_e = o_lcd_e;
    end

    initial begin : main
        int         seed;
        logic [3:0] col;
        seed    = 96977;
        i_rst_n <= 1'b0;
        i_req   <= 1'b0;
        i_func  <= FUNC_NONE;
        i_data  <= '0;
        // table covers init, data, cursor on both rows, commands and an undefined code
        add_stim(FUNC_INIT, 8'h00, 9, 1'b0, 8'h00, WAIT_37US);
        add_stim(FUNC_DATA, 8'h41, 1, 1'b1, 8'h41, WAIT_37US);
        add_stim(FUNC_DATA, 8'h7A, 1, 1'b1, 8'h7A, WAIT_37US);
        for (int r = 0; r < 4; r++) begin
            col = 4'($random(seed));
            add_stim(FUNC_SETCURSOR, {3'b000, r[0], col}, 1, 1'b0,
                     (r[0] ? 8'hC0 : 8'h80) + {4'h0, col}, WAIT_37US);
        end
        add_stim(FUNC_CMD, 8'h01, 1, 1'b0, 8'h01, WAIT_1_52MS);
        add_stim(FUNC_CMD, 8'h02, 1, 1'b0, 8'h02, WAIT_1_52MS);
        add_stim(FUNC_CMD, 8'h0C, 1, 1'b0, 8'h0C, WAIT_37US);
        add_stim(FUNC_CMD, 8'h18, 1, 1'b0, 8'h18, WAIT_37US);
        add_stim(3'd5, 8'h00, 0, 1'b0, 8'h00, WAIT_37US);
        add_stim(FUNC_DATA, 8'h30, 1, 1'b1, 8'h30, WAIT_37US);
        repeat (5) begin
            @(negedge i_clk);
            check_idle("in reset");
        end
        @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_idle("after reset");
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        repeat (10) @(posedge i_clk);
        if (exp_q.size() != 0) begin
            err_count++;
            $display("error: %0d expected E windows never appeared", exp_q.size());
        end
        $display("windows checked: %0d, errors: %0d", win_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lcd_ctrl_top.sv */
// lcd_ctrl_top: lcd controller top, command sequencer and bus driver joined by lcd_wr_if
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top #(
    parameter int CLK_FREQ = 50_000_000
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_req,
    input  lcd_pkg::lcd_func_t             i_func,
    input  logic [lcd_pkg::LCD_DATA_W-1:0] i_data,
    output logic                           o_ack,
    output logic                           o_lcd_e,
    output logic                           o_lcd_rs,
    output logic [lcd_pkg::LCD_DATA_W-1:0] o_lcd_data
);

    // one operation at a time between sequencer and driver
    lcd_wr_if wr_bus ();

    // host handshake and function decode
    lcd_cmd_sequencer lcd_cmd_sequencer_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .i_func  (i_func),
        .i_data  (i_data),
        .o_ack   (o_ack),
        .wr      (wr_bus.seq)
    );

    // pin timing, needs the clock rate for its delays
    lcd_bus_driver #(
        .CLK_FREQ (CLK_FREQ)
    ) lcd_bus_driver_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .bus        (wr_bus.drv),
        .o_lcd_e    (o_lcd_e),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_data (o_lcd_data)
    );

endmodule

`default_nettype wire

/* lcd_bus_driver.sv */
// lcd bus driver module that executes one lcd_wr_if operation, drives E, RS and DATA and times the hold
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_driver #(
    parameter int CLK_FREQ = 50_000_000
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    lcd_wr_if.drv                          bus,
    output logic                           o_lcd_e,
    output logic                           o_lcd_rs,
    output logic [lcd_pkg::LCD_DATA_W-1:0] o_lcd_data
);

    import lcd_pkg::*;

    typedef enum logic [1:0] {
        DRV_IDLE,
        DRV_HOLD,
        DRV_ACK
    } drv_state_t;

    drv_state_t         state;
    logic [DELAY_W-1:0] hold_cnt;
    logic [DELAY_W-1:0] hold_load;

    // counts down to zero, so load one less than the width
    assign hold_load = lcd_wait_cycles(CLK_FREQ, bus.wait_sel) - DELAY_W'(1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= DRV_IDLE;
            hold_cnt   <= '0;
            bus.ack    <= 1'b0;
            o_lcd_e    <= 1'b0;
            o_lcd_rs   <= 1'b0;
            o_lcd_data <= '0;
        end else begin
            case (state)
                DRV_IDLE: begin
                    if (bus.req) begin
                        hold_cnt <= hold_load;
                        state    <= DRV_HOLD;
                        // E, RS and DATA change on the same edge
                        if (bus.op == OP_WRITE) begin
                            o_lcd_e    <= 1'b1;
                            o_lcd_rs   <= bus.rs;
                            o_lcd_data <= bus.data;
                        end
                    end
                end
                DRV_HOLD: begin
                    if (hold_cnt == '0) begin
                        // E falls and ack rises together
                        o_lcd_e <= 1'b0;
                        bus.ack <= 1'b1;
                        state   <= DRV_ACK;
                    end else begin
                        hold_cnt <= hold_cnt - DELAY_W'(1);
                    end
                end
                DRV_ACK: begin
                    if (!bus.req) begin
                        bus.ack <= 1'b0;
                        state   <= DRV_IDLE;
                    end
                end
                default: state <= DRV_IDLE;
            endcase
        end
    end

    // a strobe only follows a pending request
    a_e_needs_req: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_lcd_e) |-> bus.req
    ) else $error("E rose without a request");

    // lcd latches on falling E so the payload must not move under the strobe
    a_data_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_lcd_e |-> (o_lcd_data == bus.data && o_lcd_rs == bus.rs)
    ) else $error("lcd data changed while E high");

endmodule

`default_nettype wire

/* lcd_cmd_sequencer.sv */
// lcd_cmd_sequencer: host req/ack FSM, init step table, cursor address, delay class select
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_sequencer (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_req,
    input  lcd_pkg::lcd_func_t            i_func,
    input  logic [lcd_pkg::LCD_DATA_W-1:0] i_data,
    output logic                          o_ack,
    lcd_wr_if.seq                         wr
);

    import lcd_pkg::*;

    // init runs steps 0..9, step 0 is the power-up wait
    localparam logic [3:0] INIT_LAST = 4'd9;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT_ACK,
        SEQ_WAIT_RELEASE,
        SEQ_NEXT_STEP,
        SEQ_HOST_ACK
    } seq_state_t;

    seq_state_t            state;
    logic [3:0]            step;
    logic                  last_step;

    // init table entry for current step
    lcd_op_t               init_op;
    logic [LCD_DATA_W-1:0] init_data;
    lcd_wait_t             init_wait;

    // operation chosen for the current function
    lcd_op_t               sel_op;
    logic                  sel_rs;
    logic [LCD_DATA_W-1:0] sel_data;
    lcd_wait_t             sel_wait;
    logic [LCD_DATA_W-1:0] cursor_addr;

    // row in bit 4, column in low nibble
    assign cursor_addr = (i_data[4] ? CMD_LINE_2 : CMD_LINE_1)
                       + {{(LCD_DATA_W-4){1'b0}}, i_data[3:0]};

    // single-op functions finish after step 0
    assign last_step = (i_func == FUNC_INIT) ? (step == INIT_LAST) : 1'b1;

    always_comb begin
        init_op   = OP_WRITE;
        init_data = CMD_FUNCTION_SET;
        init_wait = WAIT_100US;
        case (step)
            // power-up settle, E stays low
            4'd0: begin
                init_op   = OP_WAIT;
                init_data = '0;
                init_wait = WAIT_10MS;
            end
            4'd1: init_wait = WAIT_4_1MS;
            // steps 2..4 keep the function-set default
            4'd5: begin
                init_data = CMD_DISPLAY_OFF;
                init_wait = WAIT_37US;
            end
            4'd6: begin
                init_data = CMD_CLEAR_DISPLAY;
                init_wait = WAIT_1_52MS;
            end
            4'd7: begin
                init_data = CMD_RETURN_HOME;
                init_wait = WAIT_1_52MS;
            end
            4'd8: begin
                init_data = CMD_ENTRY_INCREASE;
                init_wait = WAIT_37US;
            end
            4'd9: begin
                init_data = CMD_DISPLAY_ON;
                init_wait = WAIT_37US;
            end
            default: ;
        endcase
    end

    always_comb begin
        sel_op   = OP_WRITE;
        sel_rs   = 1'b0;
        sel_data = i_data;
        sel_wait = WAIT_37US;
        case (i_func)
            FUNC_INIT: begin
                sel_op   = init_op;
                sel_data = init_data;
                sel_wait = init_wait;
            end
            FUNC_SETCURSOR: sel_data = cursor_addr;
            // character write into ddram
            FUNC_DATA: sel_rs = 1'b1;
            FUNC_CMD: begin
                // only clear and home need the long delay
                if (i_data == CMD_CLEAR_DISPLAY || i_data == CMD_RETURN_HOME) begin
                    sel_wait = WAIT_1_52MS;
                end
            end
            default: ;
        endcase
    end

    // control FSM
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= SEQ_IDLE;
            step   <= '0;
            o_ack  <= 1'b0;
            wr.req <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    step <= '0;
                    if (i_req) begin
                        case (i_func)
                            FUNC_INIT, FUNC_SETCURSOR, FUNC_DATA, FUNC_CMD: begin
                                state <= SEQ_ISSUE;
                            end
                            // undefined code, ack without touching the bus
                            default: begin
                                o_ack <= 1'b1;
                                state <= SEQ_HOST_ACK;
                            end
                        endcase
                    end
                end
                SEQ_ISSUE: begin
                    wr.req <= 1'b1;
                    state  <= SEQ_WAIT_ACK;
                end
                SEQ_WAIT_ACK: begin
                    if (wr.ack) begin
                        wr.req <= 1'b0;
                        state  <= SEQ_WAIT_RELEASE;
                    end
                end
                SEQ_WAIT_RELEASE: begin
                    if (!wr.ack) begin
                        if (last_step) begin
                            o_ack <= 1'b1;
                            state <= SEQ_HOST_ACK;
                        end else begin
                            state <= SEQ_NEXT_STEP;
                        end
                    end
                end
                SEQ_NEXT_STEP: begin
                    step  <= step + 4'd1;
                    state <= SEQ_ISSUE;
                end
                SEQ_HOST_ACK: begin
                    // hold ack until host drops req
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // payload loaded with the request
    always_ff @(posedge i_clk) begin
        if (state == SEQ_ISSUE) begin
            wr.op       <= sel_op;
            wr.rs       <= sel_rs;
            wr.data     <= sel_data;
            wr.wait_sel <= sel_wait;
        end
    end

    // host must hold the function code for the whole request
    a_func_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_req |=> (!i_req || $stable(i_func))
    ) else $error("i_func changed while i_req high");

endmodule

`default_nettype wire

/* lcd_wr_if.sv */
// lcd_wr_if: one lcd bus operation with req/ack handshake, seq and drv modports
`timescale 1ns/1ps
`default_nettype none

interface lcd_wr_if;

    import lcd_pkg::*;

    // four-phase handshake
    logic                  req;
    logic                  ack;

    // payload, stable while req is high
    lcd_op_t               op;
    logic                  rs;
    logic [LCD_DATA_W-1:0] data;
    lcd_wait_t             wait_sel;

    // sequencer side
    modport seq (
        output req, op, rs, data, wait_sel,
        input  ack
    );

    // bus driver side
    modport drv (
        input  req, op, rs, data, wait_sel,
        output ack
    );

endinterface

`default_nettype wire

/* lcd_pkg.sv */
// lcd_pkg: bus widths, function/op/wait enums, HD44780 command bytes, delay-cycle function
`default_nettype none

package lcd_pkg;

    // lcd data bus and hold counter widths
    localparam int LCD_DATA_W = 8;
    localparam int DELAY_W    = 32;

    // host function codes, 5..7 left undefined
    typedef enum logic [2:0] {
        FUNC_NONE      = 3'd0,
        FUNC_INIT      = 3'd1,
        FUNC_SETCURSOR = 3'd2,
        FUNC_DATA      = 3'd3,
        FUNC_CMD       = 3'd4
    } lcd_func_t;

    // one bus operation, strobe or plain wait with E low
    typedef enum logic [0:0] {
        OP_WRITE = 1'b0,
        OP_WAIT  = 1'b1
    } lcd_op_t;

    // delay classes from the HD44780 timing table
    typedef enum logic [2:0] {
        WAIT_37US   = 3'd0,
        WAIT_100US  = 3'd1,
        WAIT_1_52MS = 3'd2,
        WAIT_4_1MS  = 3'd3,
        WAIT_10MS   = 3'd4
    } lcd_wait_t;

    // instruction bytes
    localparam logic [LCD_DATA_W-1:0] CMD_CLEAR_DISPLAY  = 8'h01;
    localparam logic [LCD_DATA_W-1:0] CMD_RETURN_HOME    = 8'h02;
    localparam logic [LCD_DATA_W-1:0] CMD_ENTRY_INCREASE = 8'h06;
    localparam logic [LCD_DATA_W-1:0] CMD_DISPLAY_OFF    = 8'h08;
    localparam logic [LCD_DATA_W-1:0] CMD_DISPLAY_ON     = 8'h0C;
    // 8-bit bus, two lines, 5x8 font
    localparam logic [LCD_DATA_W-1:0] CMD_FUNCTION_SET   = 8'h38;
    // ddram base addresses
    localparam logic [LCD_DATA_W-1:0] CMD_LINE_1         = 8'h80;
    localparam logic [LCD_DATA_W-1:0] CMD_LINE_2         = 8'hC0;

    // clock cycles for a delay class, truncated to whole cycles
    function automatic logic [DELAY_W-1:0] lcd_wait_cycles(
        input longint unsigned clk_freq,
        input lcd_wait_t       sel
    );
        longint unsigned num;
        longint unsigned den;
        // duration expressed as num/den seconds
        case (sel)
            WAIT_100US:  begin num = 1;   den = 10_000;    end
            WAIT_1_52MS: begin num = 152; den = 100_000;   end
            WAIT_4_1MS:  begin num = 41;  den = 10_000;    end
            WAIT_10MS:   begin num = 1;   den = 100;       end
            default:     begin num = 37;  den = 1_000_000; end
        endcase
        // 64-bit product, 50 MHz * 152 overflows 32 bits
        return DELAY_W'((clk_freq * num) / den);
    endfunction

endpackage

`default_nettype wire
